//--- bench/clock_gen.sv
`timescale 1ns/1ns

module clock_gen (
	output logic clk_o,
	output logic reset_o
);

	localparam int HALF_PERIOD  = 10;  // 20 ns clock
	localparam int RESET_CYCLES = 3;

	initial begin
		clk_o = 1'b0;
		forever #(HALF_PERIOD) clk_o = ~clk_o;
	end

	initial begin
		reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		#1 reset_o = 1'b0;  // released just after the third edge
	end

endmodule

//--- bench/mpu_periph_sva.sv
`timescale 1ns/1ns

module mpu_periph_sva import bus_pkg::*; (
	input logic     clk_i,
	input logic     reset_i,
	input bus_req_t bus_req_i,
	input bus_rsp_t bus_rsp_o,
	input bus_req_t ext_req_o,
	input logic     irq_o
);

	logic periph_adr;  // address hits timer or controller block

	assign periph_adr = (bus_req_i.adr[31:DEC_LSB] == PIT_BASE[31:DEC_LSB]) ||
	                    (bus_req_i.adr[31:DEC_LSB] == PIC_BASE[31:DEC_LSB]);

	// ====================
	// bus rules
	// ====================
	ack_needs_cyc: assert property (@(posedge clk_i) disable iff (reset_i)
		bus_rsp_o.ack |-> bus_req_i.cyc)
		else $error("ack seen while the master holds no cycle");

	no_ext_for_periph: assert property (@(posedge clk_i) disable iff (reset_i)
		periph_adr |-> !ext_req_o.cyc)
		else $error("external cycle raised for an on-chip address");

	// irq register cleared by reset
	irq_low_after_reset: assert property (@(posedge clk_i) reset_i |=> !irq_o)
		else $error("irq_o high in the cycle after reset");

endmodule

bind mpu_periph mpu_periph_sva mpu_periph_sva_inst (
	.clk_i     (clk_i),
	.reset_i   (reset_i),
	.bus_req_i (bus_req_i),
	.bus_rsp_o (bus_rsp_o),
	.ext_req_o (ext_req_o),
	.irq_o     (irq_o)
);

//--- bench/mpu_periph_tb.sv
`timescale 1ns/1ns

// off-chip slave, acks 3 cycles after the request shows up
module ext_responder import bus_pkg::*; (
	input  logic     clk_i,
	input  logic     reset_i,
	input  bus_req_t req_i,
	output bus_rsp_t rsp_o,
	output bus_req_t last_wr_o
);
	localparam int ACK_DELAY = 3;
	logic [1:0]  wait_q = '0;
	logic        done_q = 1'b0;  // acked, waiting for stb to drop
	logic        ack_q  = 1'b0;
	logic [63:0] dat_q  = '0;
	bus_req_t    last_q = '0;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			wait_q <= '0;
			done_q <= 1'b0;
			ack_q  <= 1'b0;
			last_q <= '0;
		end else begin
			ack_q <= 1'b0;
			if (!(req_i.cyc && req_i.stb)) begin
				wait_q <= '0;
				done_q <= 1'b0;
			end else if (!done_q) begin
				if (int'(wait_q) == ACK_DELAY - 1) begin
					ack_q  <= 1'b1;
					done_q <= 1'b1;
					dat_q  <= {32'h0, req_i.adr} ^ {8{8'hA5}};  // read pattern
					if (req_i.we)
						last_q <= req_i;
				end else begin
					wait_q <= wait_q + 2'd1;
				end
			end
		end
	end

	assign rsp_o     = '{ack: ack_q, dat: dat_q};
	assign last_wr_o = last_q;
endmodule

module mpu_periph_tb import bus_pkg::*, irq_pkg::*; ();

	localparam int TIMEOUT   = 200;  // cycles per wait
	localparam int NUM_STEPS = 28;

	typedef enum logic [2:0] {
		OP_RD, OP_WR, OP_WR_EXT, OP_IRQ, OP_QUIET, OP_PULSE, OP_RAND, OP_POLL
	} op_e;

	typedef struct packed {
		op_e         op;
		logic [31:0] adr;
		logic [7:0]  sel;
		logic [63:0] wdat;  // mask for pulse, rand and poll
		logic [63:0] exp;
		logic [4:0]  cause;
	} step_t;

	logic                   clk_i;
	logic                   reset_i;
	bus_req_t               bus_req;
	bus_rsp_t               bus_rsp;
	bus_req_t               ext_req;
	bus_rsp_t               ext_rsp;
	bus_req_t               last_wr;
	logic [NUM_EXT_IRQ-1:0] irq_src;
	logic                   irq;
	logic [CAUSE_W-1:0]     cause;
	int                     err_count = 0;
	int                     timeout_count = 0;
	int                     cycle_cnt = 0;
	logic [31:0]            lfsr_q = 32'h7512965f;

	// ====================
	// stimulus table
	// ====================
	step_t steps [NUM_STEPS] = '{
		'{OP_WR,     PIT_BASE + 32'h20, 8'h0F, 64'h00C0FFEE, 64'h0, 5'd0},  // ch2 reload
		'{OP_RD,     PIT_BASE + 32'h24, 8'hF0, 64'h0, {2{32'h00C0FFEE}}, 5'd0},
		'{OP_RD,     PIT_BASE + 32'h20, 8'h0F, 64'h0, {2{32'h00C0FFEE}}, 5'd0},
		'{OP_WR,     PIC_BASE,          8'h0F, 64'h80001020, 64'h0, 5'd0},  // 31, 12, 5
		'{OP_RD,     PIC_BASE,          8'h0F, 64'h0, {2{32'h80001020}}, 5'd0},
		'{OP_WR,     PIT_BASE,          8'h0F, 64'd20, 64'h0, 5'd0},
		'{OP_WR,     PIT_BASE + 32'h08, 8'h0F, 64'h1, 64'h0, 5'd0},  // one shot
		'{OP_IRQ,    32'h0, 8'h00, 64'h0, 64'h0, 5'd31},
		'{OP_RD,     PIC_BASE + 32'h04, 8'hF0, 64'h0, {2{32'h80000000}}, 5'd0},
		'{OP_RD,     PIT_BASE + 32'h08, 8'h0F, 64'h0, 64'h0, 5'd0},  // enable gone
		'{OP_RD,     PIC_BASE + 32'h0C, 8'hF0, 64'h0, {2{32'h0000001F}}, 5'd0},
		'{OP_WR,     PIC_BASE + 32'h08, 8'h0F, 64'h80000000, 64'h0, 5'd0},
		'{OP_QUIET,  32'h0, 8'h00, 64'h0, 64'h0, 5'd0},
		'{OP_PULSE,  32'h0, 8'h00, 64'h1020, 64'h0, 5'd0},
		'{OP_IRQ,    32'h0, 8'h00, 64'h0, 64'h0, 5'd12},
		'{OP_WR,     PIC_BASE + 32'h08, 8'h0F, 64'h1000, 64'h0, 5'd0},
		'{OP_IRQ,    32'h0, 8'h00, 64'h0, 64'h0, 5'd5},
		'{OP_WR,     PIC_BASE + 32'h08, 8'h0F, 64'h20, 64'h0, 5'd0},
		'{OP_QUIET,  32'h0, 8'h00, 64'h0, 64'h0, 5'd0},
		'{OP_RAND,   PIC_BASE + 32'h04, 8'hF0, 64'h1FFF0000, 64'h0, 5'd0},  // disabled srcs
		'{OP_RD,     32'h10000040, 8'hFF, 64'h0, 64'hA5A5A5A5_B5A5A5E5, 5'd0},
		'{OP_WR_EXT, 32'h20000018, 8'h3C, 64'h01234567_89ABCDEF, 64'h0, 5'd0},
		'{OP_WR,     PIT_BASE + 32'h10, 8'h0F, 64'd10, 64'h0, 5'd0},
		'{OP_WR,     PIT_BASE + 32'h18, 8'h0F, 64'h3, 64'h0, 5'd0},  // enable + auto
		'{OP_POLL,   PIC_BASE + 32'h04, 8'hF0, 64'h40000000, {2{32'h40000000}}, 5'd0},
		'{OP_WR,     PIC_BASE + 32'h08, 8'h0F, 64'h40000000, 64'h0, 5'd0},
		'{OP_POLL,   PIC_BASE + 32'h04, 8'hF0, 64'h40000000, {2{32'h40000000}}, 5'd0},
		'{OP_WR,     PIT_BASE + 32'h18, 8'h0F, 64'h0, 64'h0, 5'd0}  // stop ch1
	};

	clock_gen clock_gen_inst (.clk_o(clk_i), .reset_o(reset_i));

	mpu_periph mpu_periph_inst (
		.clk_i     (clk_i),
		.reset_i   (reset_i),
		.bus_req_i (bus_req),
		.bus_rsp_o (bus_rsp),
		.ext_req_o (ext_req),
		.ext_rsp_i (ext_rsp),
		.irq_src_i (irq_src),
		.irq_o     (irq),
		.cause_o   (cause)
	);

	ext_responder ext_responder_inst (
		.clk_i     (clk_i),
		.reset_i   (reset_i),
		.req_i     (ext_req),
		.rsp_o     (ext_rsp),
		.last_wr_o (last_wr)
	);

	always @(posedge clk_i)
		cycle_cnt <= cycle_cnt + 1;

	// x^32 + x^22 + x^2 + x + 1, galois form
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v     = {v[30:0], lfsr_q[0]};  // one step per bit
			lfsr_q = lfsr_next(lfsr_q);
		end
		return v;
	endfunction

	task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
			err_count++;
		end
	endtask

	// ====================
	// bus master
	// ====================
	task automatic wait_ack(output logic [63:0] dat);
		int  n;
		logic got;
		n   = 0;
		got = 1'b0;
		dat = '0;
		while (!got && n < TIMEOUT) begin
			@(negedge clk_i);  // ack and data stable mid cycle
			if (bus_rsp.ack) begin
				got = 1'b1;
				dat = bus_rsp.dat;
			end else begin
				n++;
			end
		end
		if (!got) begin
			$display("timeout: no ack for address %h", bus_req.adr);
			timeout_count++;
		end
		@(posedge clk_i);
		#1 bus_req = '0;  // drop cyc and stb
	endtask

	task automatic xfer(input logic we, input logic [31:0] adr, input logic [7:0] sel,
		input logic [63:0] wdat, output logic [63:0] rd);
		@(posedge clk_i);
		#1 bus_req = '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: wdat};
		wait_ack(rd);
	endtask

	task automatic wait_irq(input logic level);
		int n;
		n = 0;
		while (irq !== level && n < TIMEOUT) begin
			@(negedge clk_i);
			n++;
		end
		if (irq !== level) begin
			$display("timeout: irq_o never went to %0b", level);
			timeout_count++;
		end
	endtask

	task automatic pulse_sources(input logic [31:0] mask);
		@(posedge clk_i);
		#1 irq_src = mask[NUM_EXT_IRQ-1:0];
		@(posedge clk_i);
		#1 irq_src = '0;
	endtask

	// one random source out of 16..28, none of them enabled
	task automatic random_pulse(input logic [31:0] adr, input logic [7:0] sel,
		input logic [31:0] mask);
		int          src;
		logic [31:0] bit_mask;
		logic [63:0] rd;
		src      = 16 + int'(rand_bits(4) % 13);
		bit_mask = 32'd1 << src;
		pulse_sources(bit_mask);
		xfer(1'b0, adr, sel, 64'h0, rd);
		check_eq("PIC_PENDING", 64'(rd[63:32] & mask), 64'(bit_mask));
		check_eq("irq_o", 64'(irq), 64'h0);
	endtask

	task automatic poll_bits(input logic [31:0] adr, input logic [7:0] sel,
		input logic [31:0] mask, input logic [63:0] exp);
		int          start;
		logic        hit;
		logic [63:0] rd;
		start = cycle_cnt;
		hit   = 1'b0;
		while (!hit && cycle_cnt - start < TIMEOUT && timeout_count == 0) begin
			xfer(1'b0, adr, sel, 64'h0, rd);
			hit = ((rd & {2{mask}}) == exp);
		end
		if (!hit && timeout_count == 0) begin
			$display("timeout: bits %h never set at address %h", mask, adr);
			timeout_count++;
		end
	endtask

	initial begin
		step_t       s;
		logic [63:0] rd;
		int          n;
		bus_req = '0;
		irq_src = '0;
		n = 0;
		while (reset_i !== 1'b0 && n < TIMEOUT) begin
			@(posedge clk_i);
			n++;
		end
		if (reset_i !== 1'b0) begin
			$display("timeout: reset never released");
			timeout_count++;
		end
		for (int idx = 0; idx < NUM_STEPS && timeout_count == 0; idx++) begin
			s = steps[idx];
			case (s.op)
				OP_RD: begin
					xfer(1'b0, s.adr, s.sel, 64'h0, rd);
					check_eq("bus_rsp_o.dat", rd, s.exp);
				end
				OP_WR:     xfer(1'b1, s.adr, s.sel, s.wdat, rd);
				OP_WR_EXT: begin
					xfer(1'b1, s.adr, s.sel, s.wdat, rd);
					check_eq("ext_req_o.adr", 64'(last_wr.adr), 64'(s.adr));
					check_eq("ext_req_o.sel", 64'(last_wr.sel), 64'(s.sel));
					check_eq("ext_req_o.dat", last_wr.dat, s.wdat);
				end
				OP_IRQ: begin
					wait_irq(1'b1);
					check_eq("cause_o", 64'(cause), 64'(s.cause));
				end
				OP_QUIET: wait_irq(1'b0);
				OP_PULSE: pulse_sources(s.wdat[31:0]);
				OP_RAND:  random_pulse(s.adr, s.sel, s.wdat[31:0]);
				default:  poll_bits(s.adr, s.sel, s.wdat[31:0], s.exp);
			endcase
		end
		$display("errors: %0d  timeouts: %0d", err_count, timeout_count);
		if (err_count == 0 && timeout_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- build.f
verilog/bus_pkg.sv
verilog/irq_pkg.sv
verilog/interval_timer.sv
verilog/irq_controller.sv
verilog/mpu_periph.sv
bench/clock_gen.sv
bench/mpu_periph_sva.sv
bench/mpu_periph_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f build.f --top-module mpu_periph_tb
./obj_dir/Vmpu_periph_tb 2>&1 | tee sim.log
if grep -q "TESTBENCH PASSED" sim.log; then
	echo "simulation ok"
else
	echo "simulation reported a failure, see sim.log"
	exit 1
fi

//--- verilog/bus_pkg.sv
package bus_pkg;

	// ====================
	// address map
	// ====================
	localparam logic [31:0] PIT_BASE = 32'hFFDC1100;  // interval timer block
	localparam logic [31:0] PIC_BASE = 32'hFFDC0F00;  // interrupt controller block
	localparam int          DEC_LSB  = 8;             // adr[31:8] picks the target

	typedef enum logic [1:0] {
		TGT_EXT,  // anything unmapped goes off-chip
		TGT_PIT,
		TGT_PIC
	} target_e;

	// ====================
	// 64-bit master side
	// ====================
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [7:0]  sel;  // byte lanes
		logic [31:0] adr;
		logic [63:0] dat;
	} bus_req_t;

	typedef struct packed {
		logic        ack;
		logic [63:0] dat;
	} bus_rsp_t;

	// 32-bit peripheral side, stb already qualified by cyc and chip select
	typedef struct packed {
		logic        stb;
		logic        we;
		logic [5:0]  adr;  // register offset, bit 2 rebuilt from sel
		logic [31:0] dat;
	} periph_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} periph_rsp_t;

endpackage

//--- verilog/interval_timer.sv
`timescale 1ns/1ns

module interval_timer import bus_pkg::*, irq_pkg::*; (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  periph_req_t           req_i,
	output periph_rsp_t           rsp_o,
	output logic [NUM_TIMERS-1:0] expire_o
);

	logic [31:0]           reload_q [NUM_TIMERS];
	logic [31:0]           count_q [NUM_TIMERS];
	logic [NUM_TIMERS-1:0] en_q;
	logic [NUM_TIMERS-1:0] auto_q;
	logic [NUM_TIMERS-1:0] expire_q;
	logic [NUM_TIMERS-1:0] zero_hit;  // channel reaches zero this cycle
	logic                  busy_q;
	logic                  ack_q;
	logic [31:0]           rdat_q;
	logic [31:0]           rdat;
	logic                  access;
	logic                  wr;
	logic [1:0]            ch;
	logic                  ch_valid;
	timer_reg_e            reg_sel;

	assign access   = req_i.stb & ~busy_q;  // first strobe cycle only
	assign wr       = access & req_i.we;
	assign ch       = req_i.adr[5:4];
	assign ch_valid = (int'(ch) < NUM_TIMERS);  // 0x30 block is empty
	assign reg_sel  = timer_reg_e'(req_i.adr[3:0]);

	always_comb begin
		for (int n = 0; n < NUM_TIMERS; n++)
			zero_hit[n] = en_q[n] & (count_q[n] <= 32'd1);
	end

	// ====================
	// counters
	// ====================
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int n = 0; n < NUM_TIMERS; n++) begin
				reload_q[n] <= '0;
				count_q[n]  <= '0;
			end
			en_q     <= '0;
			auto_q   <= '0;
			expire_q <= '0;
		end else begin
			for (int n = 0; n < NUM_TIMERS; n++) begin
				expire_q[n] <= zero_hit[n];  // single cycle pulse
				if (wr && int'(ch) == n && reg_sel == TMR_RELOAD) begin
					reload_q[n] <= req_i.dat;
					count_q[n]  <= req_i.dat;  // bus write beats counting
				end else if (zero_hit[n]) begin
					count_q[n] <= auto_q[n] ? reload_q[n] : 32'd0;
				end else if (en_q[n]) begin
					count_q[n] <= count_q[n] - 32'd1;
				end
				if (wr && int'(ch) == n && reg_sel == TMR_CTRL) begin
					en_q[n]   <= req_i.dat[CTRL_EN];
					auto_q[n] <= req_i.dat[CTRL_AUTO];
				end else if (zero_hit[n] && !auto_q[n]) begin
					en_q[n] <= 1'b0;  // one shot done
				end
			end
		end
	end

	// ====================
	// register read and ack
	// ====================
	always_comb begin
		rdat = '0;
		if (ch_valid) begin
			case (reg_sel)
				TMR_RELOAD: rdat = reload_q[ch];
				TMR_COUNT:  rdat = count_q[ch];
				TMR_CTRL:   rdat = {30'd0, auto_q[ch], en_q[ch]};
				default:    rdat = '0;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			busy_q <= 1'b0;
			ack_q  <= 1'b0;
		end else begin
			busy_q <= req_i.stb;  // held until master drops stb
			ack_q  <= access;
		end
	end

	always_ff @(posedge clk_i) begin
		if (access)
			rdat_q <= rdat;
	end

	assign rsp_o.ack = ack_q;
	assign rsp_o.dat = rdat_q;
	assign expire_o  = expire_q;

endmodule

//--- verilog/irq_controller.sv
`timescale 1ns/1ns

module irq_controller import bus_pkg::*, irq_pkg::*; (
	input  logic               clk_i,
	input  logic               reset_i,
	input  periph_req_t        req_i,
	output periph_rsp_t        rsp_o,
	input  logic [NUM_IRQ-1:0] src_i,
	output logic               irq_o,
	output logic [CAUSE_W-1:0] cause_o
);

	logic [NUM_IRQ-1:0] src_prev_q;
	logic [NUM_IRQ-1:0] pending_q;
	logic [NUM_IRQ-1:0] enable_q;
	logic [NUM_IRQ-1:0] edges;
	logic [NUM_IRQ-1:0] active;   // pending and enabled
	logic [NUM_IRQ-1:0] clr;
	logic               irq_q;
	logic [CAUSE_W-1:0] cause_q;
	logic               busy_q;
	logic               ack_q;
	logic [31:0]        rdat_q;
	logic [31:0]        rdat;
	logic               access;
	logic               wr;
	logic               in_range;
	pic_reg_e           reg_sel;

	// highest numbered set bit wins
	function automatic logic [CAUSE_W-1:0] highest(input logic [NUM_IRQ-1:0] v);
		logic [CAUSE_W-1:0] idx;
		idx = '0;
		for (int i = 0; i < NUM_IRQ; i++)
			if (v[i])
				idx = CAUSE_W'(i);
		return idx;
	endfunction

	assign access   = req_i.stb & ~busy_q;
	assign wr       = access & req_i.we;
	assign in_range = (req_i.adr[5:4] == 2'b00);  // only four regs decoded
	assign reg_sel  = pic_reg_e'(req_i.adr[3:0]);
	assign edges    = src_i & ~src_prev_q;
	assign active   = pending_q & enable_q;
	assign clr      = (wr && in_range && reg_sel == PIC_CLEAR) ? req_i.dat : '0;

	// ====================
	// edge capture, pending
	// ====================
	always_ff @(posedge clk_i)
		src_prev_q <= src_i;  // level history

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			pending_q <= '0;
			enable_q  <= '0;
			irq_q     <= 1'b0;
			cause_q   <= '0;
		end else begin
			pending_q <= (pending_q & ~clr) | edges;  // new edge wins over clear
			if (wr && in_range && reg_sel == PIC_ENABLE)
				enable_q <= req_i.dat;
			irq_q   <= |active;
			cause_q <= highest(active);
		end
	end

	// ====================
	// register read and ack
	// ====================
	always_comb begin
		rdat = '0;
		if (in_range) begin
			case (reg_sel)
				PIC_ENABLE:  rdat = enable_q;
				PIC_PENDING: rdat = pending_q;
				PIC_CAUSE:   rdat = {{(32-CAUSE_W){1'b0}}, cause_q};
				default:     rdat = '0;  // clear reg reads zero
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			busy_q <= 1'b0;
			ack_q  <= 1'b0;
		end else begin
			busy_q <= req_i.stb;
			ack_q  <= access;  // one ack per strobe
		end
	end

	always_ff @(posedge clk_i) begin
		if (access)
			rdat_q <= rdat;
	end

	assign rsp_o.ack = ack_q;
	assign rsp_o.dat = rdat_q;
	assign irq_o     = irq_q;
	assign cause_o   = cause_q;

endmodule

//--- verilog/irq_pkg.sv
package irq_pkg;

	localparam int NUM_IRQ     = 32;
	localparam int NUM_EXT_IRQ = 29;  // sources 0..28, timers take 29..31
	localparam int NUM_TIMERS  = 3;
	localparam int CAUSE_W     = $clog2(NUM_IRQ);

	// timer control register bits
	localparam int CTRL_EN   = 0;
	localparam int CTRL_AUTO = 1;

	// ====================
	// register offsets
	// ====================
	typedef enum logic [3:0] {
		TMR_RELOAD = 4'h0,  // also loads the count
		TMR_COUNT  = 4'h4,  // read only
		TMR_CTRL   = 4'h8
	} timer_reg_e;  // per channel, channel n at n*0x10

	typedef enum logic [3:0] {
		PIC_ENABLE  = 4'h0,
		PIC_PENDING = 4'h4,  // read only
		PIC_CLEAR   = 4'h8,  // write one to clear
		PIC_CAUSE   = 4'hC   // read only
	} pic_reg_e;

endpackage

//--- verilog/mpu_periph.sv
`timescale 1ns/1ns

module mpu_periph import bus_pkg::*, irq_pkg::*; (
	input  logic                   clk_i,
	input  logic                   reset_i,
	input  bus_req_t               bus_req_i,
	output bus_rsp_t               bus_rsp_o,
	output bus_req_t               ext_req_o,
	input  bus_rsp_t               ext_rsp_i,
	input  logic [NUM_EXT_IRQ-1:0] irq_src_i,
	output logic                   irq_o,
	output logic [CAUSE_W-1:0]     cause_o
);

	target_e               tgt;
	logic                  cyc_stb;
	logic                  upper;    // upper 32-bit lane in use
	logic [5:0]            adr32;
	logic [31:0]           dat32;
	periph_req_t           pit_req;
	periph_req_t           pic_req;
	periph_rsp_t           pit_rsp;
	periph_rsp_t           pic_rsp;
	logic [NUM_TIMERS-1:0] expire;
	logic [NUM_IRQ-1:0]    irq_src;
	logic                  ext_ack;
	logic                  ack_q;
	logic [63:0]           dat_q;

	// ====================
	// decode and lanes
	// ====================
	always_comb begin
		if (bus_req_i.adr[31:DEC_LSB] == PIT_BASE[31:DEC_LSB])
			tgt = TGT_PIT;
		else if (bus_req_i.adr[31:DEC_LSB] == PIC_BASE[31:DEC_LSB])
			tgt = TGT_PIC;
		else
			tgt = TGT_EXT;
	end

	assign cyc_stb = bus_req_i.cyc & bus_req_i.stb;
	assign upper   = |bus_req_i.sel[7:4];
	assign adr32   = {bus_req_i.adr[5:3], upper, 2'b00};  // a2 comes back from sel
	assign dat32   = upper ? bus_req_i.dat[63:32] : bus_req_i.dat[31:0];

	always_comb begin
		pit_req = '{stb: cyc_stb & (tgt == TGT_PIT), we: bus_req_i.we, adr: adr32, dat: dat32};
		pic_req = '{stb: cyc_stb & (tgt == TGT_PIC), we: bus_req_i.we, adr: adr32, dat: dat32};
	end

	// external port sees the cycle only when nothing on-chip claims it
	always_comb begin
		ext_req_o     = bus_req_i;
		ext_req_o.cyc = bus_req_i.cyc & (tgt == TGT_EXT);
		ext_req_o.stb = bus_req_i.stb & (tgt == TGT_EXT);
	end

	assign ext_ack = ext_rsp_i.ack & ext_req_o.cyc & ext_req_o.stb;

	// timer 0 on source 31, timer 2 on source 29
	always_comb begin
		irq_src = {{(NUM_IRQ-NUM_EXT_IRQ){1'b0}}, irq_src_i};
		for (int n = 0; n < NUM_TIMERS; n++)
			irq_src[NUM_IRQ-1-n] = expire[n];
	end

	interval_timer interval_timer_inst (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.req_i    (pit_req),
		.rsp_o    (pit_rsp),
		.expire_o (expire)
	);

	irq_controller irq_controller_inst (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.req_i   (pic_req),
		.rsp_o   (pic_rsp),
		.src_i   (irq_src),
		.irq_o   (irq_o),
		.cause_o (cause_o)
	);

	// ====================
	// response merge
	// ====================
	always_ff @(posedge clk_i) begin
		if (pic_rsp.ack)
			dat_q <= {2{pic_rsp.dat}};  // 32-bit value on both halves
		else if (pit_rsp.ack)
			dat_q <= {2{pit_rsp.dat}};
		else
			dat_q <= ext_rsp_i.dat;
	end

	always_ff @(posedge clk_i) begin
		if (reset_i)
			ack_q <= 1'b0;
		else
			ack_q <= pic_rsp.ack | pit_rsp.ack | ext_ack;
	end

	assign bus_rsp_o = '{ack: ack_q, dat: dat_q};

endmodule
